// File: include/obs_defines.svh
`ifndef OBS_DEFINES_SVH
`define OBS_DEFINES_SVH

// Observed devices and their state encoding
`define OBS_NUM_DEV   8
`define OBS_STATE_W   2

// Debug bus and bit map
`define OBS_DW        16
`define OBS_IDX_W     4
`define OBS_THR_W     8
`define OBS_CNT_W     16

// Register port
`define OBS_ADDR_W    4
`define OBS_REG_CTRL  0
`define OBS_REG_SW    1
`define OBS_REG_MAP0  2
`define OBS_REG_MAP1  3
`define OBS_REG_MAP2  4
`define OBS_REG_MAP3  5
`define OBS_REG_STATE 6
`define OBS_REG_THR   7
`define OBS_REG_CNT0  8

`endif

// File: obs.f
+incdir+include
src/obs_pkg.sv
src/obs_csr.sv
src/obs_select.sv
src/obs_rearrange.sv
src/obs_busy_counters.sv
src/obs_top.sv
tests/obs_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the observability testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f obs.f \
  --top-module obs_tb \
  -o obs_sim
if [ $? -ne 0 ]; then
  echo "Verilator compilation failed"
  exit 1
fi

output=$(./obj_dir/obs_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: src/obs_busy_counters.sv
`include "obs_defines.svh"

module obs_busy_counters (
  input  logic                              i_clk,
  input  logic                              i_rst_n,

  input  obs_pkg::obs_word_t                i_dev_state,
  input  logic [`OBS_NUM_DEV-1:0]           i_clr,

  output obs_pkg::cnt_t [`OBS_NUM_DEV-1:0]  o_cnt
);

  obs_pkg::cnt_t [`OBS_NUM_DEV-1:0] cnt_q;
  logic [`OBS_NUM_DEV-1:0]          dev_exec;

  always_comb begin
    for (int unsigned k = 0; k < `OBS_NUM_DEV; k++) begin
      dev_exec[k] = (i_dev_state[`OBS_STATE_W*k +: `OBS_STATE_W] == obs_pkg::DEV_EXEC);
    end
  end

  //////////////////////////////
  // Saturating counters
  //////////////////////////////

  // Clear has priority over counting
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cnt_q <= '0;
    end else begin
      for (int unsigned k = 0; k < `OBS_NUM_DEV; k++) begin
        if (i_clr[k]) begin
          cnt_q[k] <= '0;
        end else if (dev_exec[k] && (cnt_q[k] != '1)) begin
          cnt_q[k] <= cnt_q[k] + obs_pkg::cnt_t'(1);
        end
      end
    end
  end

  assign o_cnt = cnt_q;

  for (genvar k = 0; k < `OBS_NUM_DEV; k++) begin : g_chk
    // Only a clear from the register file may pull a count down
    a_cnt_mono: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (cnt_q[k] < $past(cnt_q[k])) |-> $past(i_clr[k]));
  end

endmodule

// File: src/obs_csr.sv
`include "obs_defines.svh"

module obs_csr (
  input  logic                                   i_clk,
  input  logic                                   i_rst_n,

  input  logic [`OBS_ADDR_W-1:0]                 i_csr_addr,
  input  obs_pkg::csr_data_t                     i_csr_wdata,
  input  logic                                   i_csr_wr,
  input  logic                                   i_csr_rd,

  input  obs_pkg::obs_word_t                     i_state_q,
  input  obs_pkg::thr_t                          i_thr_q,
  input  obs_pkg::cnt_t [`OBS_NUM_DEV-1:0]       i_cnt,

  output obs_pkg::csr_data_t                     o_csr_rdata,
  output obs_pkg::obs_mode_t                     o_mode,
  output obs_pkg::obs_word_t                     o_sw_word,
  output obs_pkg::map_idx_t [`OBS_DW-1:0]        o_map,
  output logic [`OBS_NUM_DEV-1:0]                o_cnt_clr
);

  localparam int unsigned MapPerReg = `OBS_DW / `OBS_IDX_W;

  obs_pkg::obs_mode_t                  mode_q;
  obs_pkg::obs_word_t                  sw_word_q;
  obs_pkg::map_idx_t [`OBS_DW-1:0]     map_q;
  logic [`OBS_NUM_DEV-1:0]             cnt_clr_q;
  obs_pkg::csr_data_t                  rd_mux;
  obs_pkg::csr_data_t                  rdata_q;

  // Map group 0..3 for addresses MAP0..MAP3
  logic [1:0]                          map_grp;
  logic [$clog2(`OBS_NUM_DEV)-1:0]     cnt_idx;
  logic                                cnt_sel;

  always_comb begin
    map_grp = 2'(i_csr_addr - `OBS_ADDR_W'(`OBS_REG_MAP0));
    cnt_idx = $clog2(`OBS_NUM_DEV)'(i_csr_addr - `OBS_ADDR_W'(`OBS_REG_CNT0));
    cnt_sel = (i_csr_addr >= `OBS_ADDR_W'(`OBS_REG_CNT0));
  end

  //////////////////////////////
  // Write decode
  //////////////////////////////

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mode_q    <= obs_pkg::OBS_SW;
      sw_word_q <= '0;
      // Identity map
      for (int unsigned i = 0; i < `OBS_DW; i++) begin
        map_q[i] <= obs_pkg::map_idx_t'(i);
      end
    end else if (i_csr_wr) begin
      case (i_csr_addr)
        `OBS_ADDR_W'(`OBS_REG_CTRL): mode_q <= obs_pkg::obs_mode_t'(i_csr_wdata[2:0]);
        `OBS_ADDR_W'(`OBS_REG_SW):   sw_word_q <= i_csr_wdata;
        `OBS_ADDR_W'(`OBS_REG_MAP0),
        `OBS_ADDR_W'(`OBS_REG_MAP1),
        `OBS_ADDR_W'(`OBS_REG_MAP2),
        `OBS_ADDR_W'(`OBS_REG_MAP3): begin
          for (int unsigned j = 0; j < MapPerReg; j++) begin
            map_q[MapPerReg * map_grp + j] <= i_csr_wdata[`OBS_IDX_W*j +: `OBS_IDX_W];
          end
        end
        default: ;
      endcase
    end
  end

  // One-cycle clear pulse per counter write
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cnt_clr_q <= '0;
    end else begin
      cnt_clr_q <= '0;
      if (i_csr_wr && cnt_sel) begin
        cnt_clr_q[cnt_idx] <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // Read mux
  //////////////////////////////

  always_comb begin
    rd_mux = '0;
    case (i_csr_addr)
      `OBS_ADDR_W'(`OBS_REG_CTRL): rd_mux[2:0] = mode_q;
      `OBS_ADDR_W'(`OBS_REG_SW):   rd_mux = sw_word_q;
      `OBS_ADDR_W'(`OBS_REG_MAP0),
      `OBS_ADDR_W'(`OBS_REG_MAP1),
      `OBS_ADDR_W'(`OBS_REG_MAP2),
      `OBS_ADDR_W'(`OBS_REG_MAP3): begin
        for (int unsigned j = 0; j < MapPerReg; j++) begin
          rd_mux[`OBS_IDX_W*j +: `OBS_IDX_W] = map_q[MapPerReg * map_grp + j];
        end
      end
      `OBS_ADDR_W'(`OBS_REG_STATE): rd_mux = i_state_q;
      `OBS_ADDR_W'(`OBS_REG_THR):   rd_mux[`OBS_THR_W-1:0] = i_thr_q;
      default:                      rd_mux = i_cnt[cnt_idx];
    endcase
  end

  // Read data holds until the next read
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rdata_q <= '0;
    end else if (i_csr_rd) begin
      rdata_q <= rd_mux;
    end
  end

  assign o_csr_rdata = rdata_q;
  assign o_mode      = mode_q;
  assign o_sw_word   = sw_word_q;
  assign o_map       = map_q;
  assign o_cnt_clr   = cnt_clr_q;

  // Port carries either a read or a write per cycle
  a_no_rd_wr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_csr_wr && i_csr_rd));

endmodule

// File: src/obs_pkg.sv
`include "obs_defines.svh"

package obs_pkg;

  // Per-device state as reported by each processing device
  typedef enum logic [`OBS_STATE_W-1:0] {
    DEV_IDLE  = 2'd0,
    DEV_CFG   = 2'd1,
    DEV_EXEC  = 2'd2,
    DEV_STALL = 2'd3
  } dev_state_t;

  // Debug view selection, codes 5 to 7 fall back to the software word
  typedef enum logic [2:0] {
    OBS_SW       = 3'd0,
    OBS_IDLE     = 3'd1,
    OBS_BUSY     = 3'd2,
    OBS_STATE    = 3'd3,
    OBS_THROTTLE = 3'd4
  } obs_mode_t;

  // Also used for the packed state vector, device k at bits 2k+1:2k
  typedef logic [`OBS_DW-1:0] obs_word_t;

  typedef logic [`OBS_IDX_W-1:0] map_idx_t;

  typedef logic [`OBS_THR_W-1:0] thr_t;

  typedef logic [`OBS_CNT_W-1:0] cnt_t;

  typedef logic [`OBS_DW-1:0] csr_data_t;

endpackage

// File: src/obs_rearrange.sv
`include "obs_defines.svh"

module obs_rearrange (
  input  logic                            i_clk,
  input  logic                            i_rst_n,

  input  obs_pkg::obs_word_t              i_sel_q,
  input  obs_pkg::map_idx_t [`OBS_DW-1:0] i_map,

  output obs_pkg::obs_word_t              o_obs
);

  obs_pkg::obs_word_t rearr;
  obs_pkg::obs_word_t obs_q;

  // Output bit i picks input bit map[i], duplicates allowed
  always_comb begin
    for (int unsigned i = 0; i < `OBS_DW; i++) begin
      rearr[i] = i_sel_q[i_map[i]];
    end
  end

  //////////////////////////////
  // Debug bus flops
  //////////////////////////////

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      obs_q <= '0;
    end else begin
      obs_q <= rearr;
    end
  end

  assign o_obs = obs_q;

endmodule

// File: src/obs_select.sv
`include "obs_defines.svh"

module obs_select (
  input  logic               i_clk,
  input  logic               i_rst_n,

  input  obs_pkg::obs_mode_t i_mode,
  input  obs_pkg::obs_word_t i_sw_word,
  input  obs_pkg::obs_word_t i_dev_state,
  input  obs_pkg::thr_t      i_throttle,

  output obs_pkg::obs_word_t o_sel_q,
  output obs_pkg::obs_word_t o_state_q,
  output obs_pkg::thr_t      o_thr_q
);

  logic [`OBS_NUM_DEV-1:0] dev_idle;
  logic [`OBS_NUM_DEV-1:0] dev_exec;
  logic [`OBS_NUM_DEV-1:0] dev_stall;

  obs_pkg::obs_word_t      sel;
  obs_pkg::obs_word_t      sel_q;
  obs_pkg::obs_word_t      state_q;
  obs_pkg::thr_t           thr_q;

  // Decode per-device state flags
  always_comb begin
    for (int unsigned k = 0; k < `OBS_NUM_DEV; k++) begin
      dev_idle[k]  = (i_dev_state[`OBS_STATE_W*k +: `OBS_STATE_W] == obs_pkg::DEV_IDLE);
      dev_exec[k]  = (i_dev_state[`OBS_STATE_W*k +: `OBS_STATE_W] == obs_pkg::DEV_EXEC);
      dev_stall[k] = (i_dev_state[`OBS_STATE_W*k +: `OBS_STATE_W] == obs_pkg::DEV_STALL);
    end
  end

  //////////////////////////////
  // View mux
  //////////////////////////////

  always_comb begin
    sel = '0;
    case (i_mode)
      obs_pkg::OBS_IDLE: begin
        sel[`OBS_NUM_DEV-1:0]           = dev_idle;
        sel[`OBS_DW-1:`OBS_NUM_DEV]     = dev_stall;
      end
      obs_pkg::OBS_BUSY: begin
        sel[`OBS_NUM_DEV-1:0]           = dev_exec;
        sel[`OBS_DW-1:`OBS_NUM_DEV]     = i_throttle;
      end
      obs_pkg::OBS_STATE: begin
        sel = i_dev_state;
      end
      obs_pkg::OBS_THROTTLE: begin
        sel[0]             = i_sw_word[0];
        sel[`OBS_THR_W:1]  = i_throttle;
      end
      // OBS_SW and the unused codes
      default: begin
        sel = i_sw_word;
      end
    endcase
  end

  // Stage one flops, view plus readback snapshot
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      sel_q   <= '0;
      state_q <= '0;
      thr_q   <= '0;
    end else begin
      sel_q   <= sel;
      state_q <= i_dev_state;
      thr_q   <= i_throttle;
    end
  end

  assign o_sel_q   = sel_q;
  assign o_state_q = state_q;
  assign o_thr_q   = thr_q;

  a_sel_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !$isunknown(o_sel_q));

endmodule

// File: src/obs_top.sv
`include "obs_defines.svh"

module obs_top (
  input  logic                    i_clk,
  input  logic                    i_rst_n,

  input  obs_pkg::obs_word_t      i_dev_state,
  input  obs_pkg::thr_t           i_throttle,

  input  logic [`OBS_ADDR_W-1:0]  i_csr_addr,
  input  obs_pkg::csr_data_t      i_csr_wdata,
  input  logic                    i_csr_wr,
  input  logic                    i_csr_rd,
  output obs_pkg::csr_data_t      o_csr_rdata,

  output obs_pkg::obs_word_t      o_obs
);

  obs_pkg::obs_mode_t                  mode;
  obs_pkg::obs_word_t                  sw_word;
  obs_pkg::map_idx_t [`OBS_DW-1:0]     map;
  obs_pkg::obs_word_t                  sel_q;
  obs_pkg::obs_word_t                  state_q;
  obs_pkg::thr_t                       thr_q;
  obs_pkg::cnt_t [`OBS_NUM_DEV-1:0]    cnt;
  logic [`OBS_NUM_DEV-1:0]             cnt_clr;

  obs_csr u_csr (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_csr_addr  (i_csr_addr),
    .i_csr_wdata (i_csr_wdata),
    .i_csr_wr    (i_csr_wr),
    .i_csr_rd    (i_csr_rd),
    .i_state_q   (state_q),
    .i_thr_q     (thr_q),
    .i_cnt       (cnt),
    .o_csr_rdata (o_csr_rdata),
    .o_mode      (mode),
    .o_sw_word   (sw_word),
    .o_map       (map),
    .o_cnt_clr   (cnt_clr)
  );

  // Stage one
  obs_select u_select (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_mode      (mode),
    .i_sw_word   (sw_word),
    .i_dev_state (i_dev_state),
    .i_throttle  (i_throttle),
    .o_sel_q     (sel_q),
    .o_state_q   (state_q),
    .o_thr_q     (thr_q)
  );

  // Stage two
  obs_rearrange u_rearrange (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_sel_q (sel_q),
    .i_map   (map),
    .o_obs   (o_obs)
  );

  obs_busy_counters u_busy_counters (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_dev_state (i_dev_state),
    .i_clr       (cnt_clr),
    .o_cnt       (cnt)
  );

endmodule

// File: tests/obs_tb.sv
`include "obs_defines.svh"

module obs_tb;

  localparam int NUM_TESTS    = 13;
  localparam int CYC_PER_TEST = 12;
  localparam int CNT_TEST_CYC = 80;
  localparam int MARGIN       = 60;
  localparam int MAX_CYCLES   = NUM_TESTS * CYC_PER_TEST + CNT_TEST_CYC + MARGIN;
  localparam int HOLD_A       = 20;
  localparam int HOLD_B       = 5;

  localparam logic [1:0] MAP_ID  = 2'd0;
  localparam logic [1:0] MAP_REV = 2'd1;
  localparam logic [1:0] MAP_RND = 2'd2;

  // Mode code, software word and map choice per test
  localparam logic [2:0] TBL_MODE [NUM_TESTS] = '{
    3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6, 3'd7, 3'd1, 3'd3, 3'd2, 3'd4, 3'd0};
  localparam logic [15:0] TBL_SW [NUM_TESTS] = '{
    16'ha5c3, 16'h0f0f, 16'h1234, 16'hffff, 16'h0001, 16'h5a5a, 16'hc0de,
    16'h8001, 16'h3c3c, 16'h0000, 16'h7e81, 16'h0000, 16'h9bd1};
  localparam logic [1:0] TBL_MAP [NUM_TESTS] = '{
    MAP_ID, MAP_ID, MAP_ID, MAP_ID, MAP_ID, MAP_ID, MAP_ID,
    MAP_ID, MAP_REV, MAP_REV, MAP_RND, MAP_RND, MAP_RND};

  logic                    i_clk;
  logic                    i_rst_n;
  obs_pkg::obs_word_t      i_dev_state;
  obs_pkg::thr_t           i_throttle;
  logic [`OBS_ADDR_W-1:0]  i_csr_addr;
  obs_pkg::csr_data_t      i_csr_wdata;
  logic                    i_csr_wr;
  logic                    i_csr_rd;
  obs_pkg::csr_data_t      o_csr_rdata;
  obs_pkg::obs_word_t      o_obs;

  obs_pkg::obs_word_t      tbl_state [NUM_TESTS];
  obs_pkg::thr_t           tbl_thr   [NUM_TESTS];
  obs_pkg::map_idx_t       cur_map   [`OBS_DW];
  int                      seed;
  int                      cycles = 0;
  int                      obs_errs = 0;
  int                      csr_errs = 0;
  int                      cnt_errs = 0;

  obs_top uut (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_dev_state (i_dev_state),
    .i_throttle  (i_throttle),
    .i_csr_addr  (i_csr_addr),
    .i_csr_wdata (i_csr_wdata),
    .i_csr_wr    (i_csr_wr),
    .i_csr_rd    (i_csr_rd),
    .o_csr_rdata (o_csr_rdata),
    .o_obs       (o_obs)
  );

  always #2 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_obs(input string name, input obs_pkg::obs_word_t exp,
                           input obs_pkg::obs_word_t got);
    if (got !== exp) begin
      obs_errs++;
      $display("ERR t=%0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_csr(input string name, input obs_pkg::csr_data_t exp,
                           input obs_pkg::csr_data_t got);
    if (got !== exp) begin
      csr_errs++;
      $display("ERR t=%0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_cnt(input string name, input obs_pkg::cnt_t exp,
                           input obs_pkg::cnt_t got);
    if (got !== exp) begin
      cnt_errs++;
      $display("ERR t=%0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  //////////////////////////////
  // Register port
  //////////////////////////////

  task automatic reg_write(input logic [`OBS_ADDR_W-1:0] addr, input obs_pkg::csr_data_t data);
    i_csr_addr  = addr;
    i_csr_wdata = data;
    i_csr_wr    = 1'b1;
    @(negedge i_clk);
    i_csr_wr    = 1'b0;
  endtask

  // Data is valid at the negedge after the capturing edge
  task automatic reg_read(input logic [`OBS_ADDR_W-1:0] addr);
    i_csr_addr = addr;
    i_csr_rd   = 1'b1;
    @(negedge i_clk);
    i_csr_rd   = 1'b0;
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic obs_pkg::obs_word_t expected_view(input logic [2:0] mode,
      input obs_pkg::obs_word_t sw, input obs_pkg::obs_word_t st, input obs_pkg::thr_t thr);
    obs_pkg::obs_word_t v;
    logic [1:0]         s;
    v = '0;
    for (int k = 0; k < `OBS_NUM_DEV; k++) begin
      s = st[2*k +: 2];
      case (mode)
        3'd1: begin
          v[k]     = (s == obs_pkg::DEV_IDLE);
          v[k + 8] = (s == obs_pkg::DEV_STALL);
        end
        3'd2: v[k] = (s == obs_pkg::DEV_EXEC);
        default: ;
      endcase
    end
    case (mode)
      3'd2: v[15:8] = thr;
      3'd3: v = st;
      3'd4: begin
        v[0]   = sw[0];
        v[8:1] = thr;
      end
      3'd1: ;
      default: v = sw;
    endcase
    return v;
  endfunction

  function automatic obs_pkg::obs_word_t permute(input obs_pkg::obs_word_t v);
    obs_pkg::obs_word_t r;
    for (int i = 0; i < `OBS_DW; i++) begin
      r[i] = v[cur_map[i]];
    end
    return r;
  endfunction

  task automatic build_map(input logic [1:0] choice);
    logic [31:0] r;
    for (int i = 0; i < `OBS_DW; i++) begin
      r = $random(seed);
      case (choice)
        MAP_REV: cur_map[i] = obs_pkg::map_idx_t'(`OBS_DW - 1 - i);
        MAP_RND: cur_map[i] = r[3:0];
        default: cur_map[i] = obs_pkg::map_idx_t'(i);
      endcase
    end
  endtask

  // Four indices per map register, lowest output bit in the low nibble
  function automatic obs_pkg::csr_data_t map_word(input int grp);
    return {cur_map[4*grp+3], cur_map[4*grp+2], cur_map[4*grp+1], cur_map[4*grp]};
  endfunction

  task automatic fill_table();
    logic [31:0] r;
    for (int t = 0; t < NUM_TESTS; t++) begin
      r = $random(seed);
      tbl_state[t] = r[15:0];
      r = $random(seed);
      tbl_thr[t] = r[7:0];
    end
  endtask

  task automatic read_counters(input int exp_cnt [`OBS_NUM_DEV]);
    for (int k = 0; k < `OBS_NUM_DEV; k++) begin
      reg_read(`OBS_ADDR_W'(`OBS_REG_CNT0 + k));
      check_cnt($sformatf("cnt[%0d]", k), obs_pkg::cnt_t'(exp_cnt[k]),
                obs_pkg::cnt_t'(o_csr_rdata));
    end
  endtask

  //////////////////////////////
  // Test sections
  //////////////////////////////

  task automatic check_reset();
    int zeros [`OBS_NUM_DEV];
    check_obs("o_obs", '0, o_obs);
    check_csr("o_csr_rdata", '0, o_csr_rdata);
    reg_read(`OBS_ADDR_W'(`OBS_REG_CTRL));
    check_csr("o_csr_rdata(CTRL)", '0, o_csr_rdata);
    build_map(MAP_ID);
    for (int g = 0; g < 4; g++) begin
      reg_read(`OBS_ADDR_W'(`OBS_REG_MAP0 + g));
      check_csr($sformatf("o_csr_rdata(MAP%0d)", g), map_word(g), o_csr_rdata);
    end
    for (int k = 0; k < `OBS_NUM_DEV; k++) begin
      zeros[k] = 0;
    end
    read_counters(zeros);
  endtask

  task automatic run_table();
    obs_pkg::obs_word_t exp;
    for (int t = 0; t < NUM_TESTS; t++) begin
      i_dev_state = tbl_state[t];
      i_throttle  = tbl_thr[t];
      build_map(TBL_MAP[t]);
      reg_write(`OBS_ADDR_W'(`OBS_REG_CTRL), {13'd0, TBL_MODE[t]});
      reg_write(`OBS_ADDR_W'(`OBS_REG_SW), TBL_SW[t]);
      for (int g = 0; g < 4; g++) begin
        reg_write(`OBS_ADDR_W'(`OBS_REG_MAP0 + g), map_word(g));
      end
      // Map write reaches the bus two edges later
      repeat (2) @(negedge i_clk);
      exp = permute(expected_view(TBL_MODE[t], TBL_SW[t], tbl_state[t], tbl_thr[t]));
      check_obs($sformatf("o_obs(test %0d)", t), exp, o_obs);
      reg_read(`OBS_ADDR_W'(`OBS_REG_STATE));
      check_csr("o_csr_rdata(STATE)", tbl_state[t], o_csr_rdata);
      reg_read(`OBS_ADDR_W'(`OBS_REG_THR));
      check_csr("o_csr_rdata(THR)", {8'd0, tbl_thr[t]}, o_csr_rdata);
      reg_read(`OBS_ADDR_W'(`OBS_REG_CTRL));
      check_csr("o_csr_rdata(CTRL)", {13'd0, TBL_MODE[t]}, o_csr_rdata);
    end
  endtask

  task automatic run_counter_test();
    obs_pkg::obs_word_t pattern;
    int                 exp_cnt [`OBS_NUM_DEV];
    // Device 7 down to device 0
    pattern = {obs_pkg::DEV_EXEC, obs_pkg::DEV_IDLE, obs_pkg::DEV_EXEC, obs_pkg::DEV_CFG,
               obs_pkg::DEV_STALL, obs_pkg::DEV_EXEC, obs_pkg::DEV_IDLE, obs_pkg::DEV_EXEC};
    i_dev_state = '0;
    for (int k = 0; k < `OBS_NUM_DEV; k++) begin
      reg_write(`OBS_ADDR_W'(`OBS_REG_CNT0 + k), '0);
      exp_cnt[k] = 0;
    end
    @(negedge i_clk);
    read_counters(exp_cnt);
    i_dev_state = pattern;
    repeat (HOLD_A) @(negedge i_clk);
    i_dev_state = '0;
    for (int k = 0; k < `OBS_NUM_DEV; k++) begin
      if (pattern[2*k +: 2] == obs_pkg::DEV_EXEC) exp_cnt[k] += HOLD_A;
    end
    read_counters(exp_cnt);
    // Clear device 2 only, then count again
    reg_write(`OBS_ADDR_W'(`OBS_REG_CNT0 + 2), '0);
    exp_cnt[2] = 0;
    @(negedge i_clk);
    i_dev_state = pattern;
    repeat (HOLD_B) @(negedge i_clk);
    i_dev_state = '0;
    for (int k = 0; k < `OBS_NUM_DEV; k++) begin
      if (pattern[2*k +: 2] == obs_pkg::DEV_EXEC) exp_cnt[k] += HOLD_B;
    end
    read_counters(exp_cnt);
  endtask

  initial begin
    seed        = 32'h4bc2_98be;
    i_clk       = 1'b0;
    i_rst_n     = 1'b0;
    i_dev_state = '0;
    i_throttle  = '0;
    i_csr_addr  = '0;
    i_csr_wdata = '0;
    i_csr_wr    = 1'b0;
    i_csr_rd    = 1'b0;
    fill_table();
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;
    check_reset();
    run_table();
    run_counter_test();
    $display("Errors: obs %0d, csr %0d, cnt %0d", obs_errs, csr_errs, cnt_errs);
    if (obs_errs + csr_errs + cnt_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
